// File: run_sim.sh
#!/bin/sh
# compile and run the dlx_core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_dlx_core \
    -f tb.f -Mdir obj_dir -o tb_dlx_core > build.log 2>&1 \
    && ./obj_dir/tb_dlx_core > sim.log 2>&1

grep -q "^TEST OK$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: sim/tb_dlx_core.sv
// ==============================
// self-checking testbench for dlx_core
// stores are checked in order against an ISA-level model
// both memories are 64 words and addresses wrap
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_dlx_core;

    typedef struct packed {
        isa_pkg::word_t addr;
        isa_pkg::word_t data;
    } store_t;

    localparam int MEM_WORDS    = 64;
    localparam int STORE_WAIT   = 2000; // cycles allowed for all stores
    localparam int QUIET_CYCLES = 12;   // late or duplicate stores show up here
    localparam int MODEL_STEPS  = 1000; // model gives up past this

    logic               clock;
    logic               rst_n;
    logic [`DATA_W-1:0] address_imem;
    logic [`DATA_W-1:0] q_imem;
    logic [`DATA_W-1:0] address_dmem;
    logic [`DATA_W-1:0] data;
    logic               wren;
    logic [`DATA_W-1:0] q_dmem;

    logic [`DATA_W-1:0] imem [0:MEM_WORDS-1];
    logic [`DATA_W-1:0] dmem [0:MEM_WORDS-1];
    store_t             exp_q [$];         // from the model
    store_t             obs_q [$];         // seen on the bus
    integer             seed         = 32'hacf7;
    int                 value_errors = 0;  // main process only
    int                 other_errors = 0;
    int                 store_errors = 0;  // monitor only
    int                 extra_stores = 0;
    int                 cycles;
    int                 n_exp;

    dlx_core DUT (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    assign q_imem = imem[address_imem[5:0]]; // combinational read in the same cycle
    assign q_dmem = dmem[address_dmem[5:0]];

    always #10 clock = ~clock; // 20 ns period

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[5:0]] <= data; // single-cycle write
        end
    end

    function automatic logic [31:0] enc_r(isa_pkg::alu_op_e fn, int rd, int rs, int rt, int sh);
        return {isa_pkg::op_alu, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn, 2'b00};
    endfunction

    // addi, lw, sw, bne, blt share this layout
    function automatic logic [31:0] enc_i(isa_pkg::opcode_e op, int rd, int rs, int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] enc_j(int target);
        return {isa_pkg::op_j, target[26:0]};
    endfunction

    task automatic load_program();
        imem[0]  = enc_i(isa_pkg::op_addi, 1, 0, 5);
        imem[1]  = enc_i(isa_pkg::op_addi, 2, 0, 12);
        imem[2]  = enc_r(isa_pkg::alu_add, 3, 1, 2, 0);  // MX on r2 and WX on r1
        imem[3]  = enc_r(isa_pkg::alu_sub, 4, 3, 1, 0);
        imem[4]  = enc_r(isa_pkg::alu_and, 5, 4, 1, 0);
        imem[5]  = enc_r(isa_pkg::alu_or, 6, 5, 4, 0);
        imem[6]  = enc_r(isa_pkg::alu_sll, 7, 6, 0, 3);
        imem[7]  = enc_r(isa_pkg::alu_sra, 8, 7, 0, 2);
        imem[8]  = enc_i(isa_pkg::op_addi, 9, 0, -40);   // negative imm
        imem[9]  = enc_r(isa_pkg::alu_sra, 10, 9, 0, 1); // sign fill
        for (int i = 0; i < 8; i++) begin
            imem[10 + i] = enc_i(isa_pkg::op_sw, 3 + i, 0, 32 + i);
        end
        imem[18] = enc_r(isa_pkg::alu_add, 11, 9, 1, 0);
        imem[19] = enc_i(isa_pkg::op_sw, 11, 0, 40);     // data made just before
        imem[20] = enc_i(isa_pkg::op_lw, 12, 0, 3);
        imem[21] = enc_r(isa_pkg::alu_add, 13, 12, 1, 0); // load-use stall
        imem[22] = enc_i(isa_pkg::op_sw, 13, 0, 41);
        imem[23] = enc_i(isa_pkg::op_lw, 14, 0, 5);
        imem[24] = enc_i(isa_pkg::op_sw, 14, 0, 42);     // lw then sw data
        imem[25] = enc_i(isa_pkg::op_addi, 0, 0, 77);    // r0 stays zero
        imem[26] = enc_r(isa_pkg::alu_add, 0, 1, 2, 0);
        imem[27] = enc_i(isa_pkg::op_sw, 0, 0, 43);
        imem[28] = enc_i(isa_pkg::op_bne, 1, 2, 1);      // taken
        imem[29] = enc_i(isa_pkg::op_sw, 1, 0, 50);      // wrong path
        imem[30] = enc_i(isa_pkg::op_bne, 1, 1, 1);      // not taken
        imem[31] = enc_i(isa_pkg::op_sw, 2, 0, 44);
        imem[32] = enc_i(isa_pkg::op_blt, 9, 1, 1);      // taken since -40 < 5
        imem[33] = enc_i(isa_pkg::op_sw, 1, 0, 51);      // wrong path
        imem[34] = enc_i(isa_pkg::op_blt, 1, 9, 1);      // not taken
        imem[35] = enc_i(isa_pkg::op_sw, 4, 0, 45);
        imem[36] = enc_i(isa_pkg::op_addi, 16, 0, 3);
        imem[37] = enc_i(isa_pkg::op_bne, 16, 0, 1);     // stalls on the ALU result
        imem[38] = enc_i(isa_pkg::op_sw, 1, 0, 52);      // wrong path
        imem[39] = enc_i(isa_pkg::op_lw, 17, 0, 40);     // reads back -35
        imem[40] = enc_i(isa_pkg::op_blt, 17, 0, 1);     // taken only on the loaded value
        imem[41] = enc_i(isa_pkg::op_sw, 17, 0, 46);     // wrong path
        imem[42] = enc_j(44);
        imem[43] = enc_i(isa_pkg::op_sw, 1, 0, 53);      // wrong path
        imem[44] = enc_i(isa_pkg::op_sw, 16, 0, 47);
        imem[45] = enc_i(isa_pkg::op_addi, 18, 0, 0);
        imem[46] = enc_i(isa_pkg::op_addi, 19, 0, 3);
        imem[47] = enc_i(isa_pkg::op_addi, 18, 18, 1);   // loop top
        imem[48] = enc_i(isa_pkg::op_sw, 18, 18, 54);
        imem[49] = enc_i(isa_pkg::op_blt, 18, 19, -3);   // back to 47
        imem[50] = enc_j(50);                            // halt
    endtask

    // steps one insn at a time and fills exp_q
    function automatic int run_reference();
        isa_pkg::word_t regs [0:`NUM_REGS-1];
        isa_pkg::word_t mem [0:MEM_WORDS-1];
        isa_pkg::word_t pc;
        isa_pkg::word_t next_pc;
        isa_pkg::word_t imm;
        isa_pkg::word_t addr;
        isa_pkg::word_t res;
        logic [31:0]    w;
        logic [4:0]     opc;
        logic [4:0]     rd;
        logic [4:0]     rs;
        logic [4:0]     rt;
        logic [4:0]     sh;
        logic [4:0]     fn;
        logic           halted;
        int             steps;
        for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = dmem[i];
        end
        exp_q.delete();
        pc     = `RESET_PC;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < MODEL_STEPS) begin
            w       = imem[pc[5:0]];
            opc     = w[31:27];
            rd      = w[26:22];
            rs      = w[21:17];
            rt      = w[16:12];
            sh      = w[11:7];
            fn      = w[6:2];
            imm     = {{15{w[16]}}, w[16:0]}; // 17-bit sign extend
            addr    = regs[rs] + imm;
            next_pc = pc + 1;
            case (opc)
                isa_pkg::op_alu: begin
                    case (fn)
                        isa_pkg::alu_add: res = regs[rs] + regs[rt];
                        isa_pkg::alu_sub: res = regs[rs] - regs[rt];
                        isa_pkg::alu_and: res = regs[rs] & regs[rt];
                        isa_pkg::alu_or:  res = regs[rs] | regs[rt];
                        isa_pkg::alu_sll: res = regs[rs] << sh;
                        isa_pkg::alu_sra: res = $signed(regs[rs]) >>> sh;
                        default:          res = '0;
                    endcase
                    regs[rd] = res;
                end
                isa_pkg::op_addi: regs[rd] = addr;
                isa_pkg::op_lw:   regs[rd] = mem[addr[5:0]];
                isa_pkg::op_sw: begin
                    mem[addr[5:0]] = regs[rd];
                    exp_q.push_back(store_t'({addr, regs[rd]}));
                end
                isa_pkg::op_bne: begin
                    if (regs[rd] != regs[rs]) next_pc = pc + 1 + imm;
                end
                isa_pkg::op_blt: begin
                    if ($signed(regs[rd]) < $signed(regs[rs])) next_pc = pc + 1 + imm;
                end
                isa_pkg::op_j: begin
                    next_pc = {5'b0, w[26:0]};
                    halted  = next_pc == pc; // jump to self ends the program
                end
                default: ;
            endcase
            regs[0] = '0; // r0 writes are lost
            pc      = next_pc;
            steps++;
        end
        if (!halted) begin
            $display("reference model did not reach the halt loop");
            return -1;
        end
        return exp_q.size();
    endfunction

    task automatic check_store(string name, store_t expected, store_t actual);
        if (expected !== actual) begin
            $display("error %s: expected addr %h data %h, actual addr %h data %h",
                     name, expected.addr, expected.data, actual.addr, actual.data);
            store_errors++;
        end
    endtask

    task automatic check_word(string name, isa_pkg::word_t expected, isa_pkg::word_t actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("error %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_reset();
        check_word("reset fetch address", `RESET_PC, address_imem);
        check_bit("reset wren", 1'b0, wren);
    endtask

    // samples mid-cycle and logs each cycle with wren high
    always @(negedge clock) begin
        if (rst_n === 1'b1 && wren === 1'b1) begin
            obs_q.push_back(store_t'({address_dmem, data}));
            if (obs_q.size() > exp_q.size()) begin
                $display("unexpected store number %0d to address %h, model has only %0d",
                         obs_q.size(), address_dmem, exp_q.size());
                extra_stores++;
            end else begin
                check_store($sformatf("store %0d", obs_q.size() - 1),
                            exp_q[obs_q.size() - 1], obs_q[obs_q.size() - 1]);
            end
        end
    end

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = isa_pkg::NOP;
            dmem[i] = $random(seed);
        end
        load_program();
        n_exp = run_reference(); // before the DUT touches dmem
        if (n_exp < 0) begin
            other_errors++;
        end
        repeat (7) @(posedge clock);
        @(negedge clock);
        check_reset();
        @(posedge clock);
        rst_n <= 1'b1; // 8th edge ends reset
        cycles = 0;
        while (obs_q.size() < n_exp && cycles < STORE_WAIT) begin
            @(posedge clock);
            cycles++;
        end
        if (obs_q.size() < n_exp) begin
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, obs_q.size(), n_exp);
            other_errors++;
        end
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("errors: %0d wrong values, %0d other failures",
                 value_errors + store_errors, other_errors + extra_stores);
        if (value_errors + store_errors + other_errors + extra_stores == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: source/alu.sv
// ==============================
// combinational ALU plus signed compare of a vs b
// unknown op gives zero
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu (
    input  logic [`DATA_W-1:0] operand_a,
    input  logic [`DATA_W-1:0] operand_b,
    input  isa_pkg::alu_op_e   op,
    input  logic [4:0]         shamt,
    output logic [`DATA_W-1:0] result,
    output logic               not_equal,
    output logic               less_than
);

    always_comb begin
        case (op)
            isa_pkg::alu_add: begin
                result = operand_a + operand_b; // wraps, no overflow code
            end
            isa_pkg::alu_sub: begin
                result = operand_a - operand_b;
            end
            isa_pkg::alu_and: begin
                result = operand_a & operand_b;
            end
            isa_pkg::alu_or: begin
                result = operand_a | operand_b;
            end
            isa_pkg::alu_sll: begin
                result = operand_a << shamt; // operand_b ignored for shifts
            end
            isa_pkg::alu_sra: begin
                result = $signed(operand_a) >>> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // flags for bne/blt, always valid whatever op is
    assign not_equal = operand_a != operand_b;
    assign less_than = $signed(operand_a) < $signed(operand_b);

endmodule

// File: source/cpu_config.svh
// ==============================
// core size and reset constants
// register fields are fixed at 5 bits by the insn format
// ==============================
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data word and address width
`define DATA_W 32

// register index width
`define REG_ADDR_W 5

// r0 counted, always reads zero
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/decode_stage.sv
// ==============================
// fetch and decode, branches resolved here
// one-cycle taken penalty, stall freezes PC and F/D
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module decode_stage (
    input  logic                   clock,
    input  logic                   rst_n,
    output logic [`DATA_W-1:0]     address_imem,
    input  isa_pkg::insn_t         q_imem,
    output logic [`REG_ADDR_W-1:0] rd_addr_a,
    output logic [`REG_ADDR_W-1:0] rd_addr_b,
    input  logic [`DATA_W-1:0]     rd_data_a,
    input  logic [`DATA_W-1:0]     rd_data_b,
    input  isa_pkg::insn_t         dx_insn,
    input  isa_pkg::insn_t         xm_insn,
    input  pipe_pkg::fwd_t         xm_fwd,
    input  pipe_pkg::fwd_t         mw_fwd,
    output pipe_pkg::dx_t          dx_next,
    output logic                   dx_load
);

    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] seq_pc;
    logic [`DATA_W-1:0] fd_pc;     // pc + 1 of the F/D insn
    isa_pkg::insn_t     fd_insn;
    logic               is_bne;
    logic               is_blt;
    logic               is_br;
    logic               is_j;
    logic               uses_a;
    logic               uses_b;
    logic               hit_dx_a;
    logic               hit_dx_b;
    logic               load_use;
    logic               br_dx;
    logic               br_xm;
    logic               stall;
    logic               take;
    logic               ne;
    logic               lt;
    logic [`DATA_W-1:0] cmp_a;
    logic [`DATA_W-1:0] cmp_b;
    logic [`DATA_W-1:0] br_target;

    assign address_imem = pc;
    assign seq_pc       = pc + 1; // word addressed

    assign is_bne = fd_insn.opcode == isa_pkg::op_bne;
    assign is_blt = fd_insn.opcode == isa_pkg::op_blt;
    assign is_br  = is_bne || is_blt;
    assign is_j   = fd_insn.opcode == isa_pkg::op_j;

    assign rd_addr_a = fd_insn.rs;
    assign rd_addr_b = (fd_insn.opcode == isa_pkg::op_alu) ? fd_insn.rt : fd_insn.rd;
    assign uses_a    = !is_j; // j reads nothing
    assign uses_b    = fd_insn.opcode == isa_pkg::op_alu || fd_insn.opcode == isa_pkg::op_sw
                       || is_br;

    // D/X producer matches a source of F/D
    assign hit_dx_a = isa_pkg::writes_rd(dx_insn) && dx_insn.rd == rd_addr_a && uses_a;
    assign hit_dx_b = isa_pkg::writes_rd(dx_insn) && dx_insn.rd == rd_addr_b && uses_b;

    // sw data skips this, the memory stage bypasses it
    assign load_use = dx_insn.opcode == isa_pkg::op_lw
                      && (hit_dx_a || (hit_dx_b && fd_insn.opcode != isa_pkg::op_sw));
    assign br_dx    = is_br && (hit_dx_a || hit_dx_b); // compare needs value now
    assign br_xm    = is_br && xm_insn.opcode == isa_pkg::op_lw && xm_fwd.wr
                      && (xm_fwd.rd == rd_addr_a || xm_fwd.rd == rd_addr_b); // load not back yet
    assign stall    = load_use || br_dx || br_xm;

    // XM over MW over regfile, a side is rd
    assign cmp_a = pipe_pkg::fwd_sel(rd_addr_b,
                       pipe_pkg::fwd_sel(rd_addr_b, rd_data_b, mw_fwd), xm_fwd);
    assign cmp_b = pipe_pkg::fwd_sel(rd_addr_a,
                       pipe_pkg::fwd_sel(rd_addr_a, rd_data_a, mw_fwd), xm_fwd);

    alu u_branch_cmp (
        .operand_a (cmp_a),
        .operand_b (cmp_b),
        .op        (isa_pkg::alu_sub),
        .shamt     (5'd0),
        .result    (),
        .not_equal (ne),
        .less_than (lt)
    );

    assign take      = !stall && (is_j || (is_bne && ne) || (is_blt && lt));
    assign br_target = is_j ? isa_pkg::jump_target(fd_insn)
                            : fd_pc + isa_pkg::imm_sext(fd_insn); // relative to pc + 1

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `RESET_PC;
            fd_pc   <= '0;
            fd_insn <= isa_pkg::NOP;
        end else if (!stall) begin
            pc      <= take ? br_target : seq_pc;
            fd_pc   <= seq_pc;
            fd_insn <= take ? isa_pkg::NOP : q_imem; // squash wrong-path fetch
        end
    end

    // WB write lands after this read, so bypass MW here
    assign dx_next.rs_val = pipe_pkg::fwd_sel(rd_addr_a, rd_data_a, mw_fwd);
    assign dx_next.rt_val = pipe_pkg::fwd_sel(rd_addr_b, rd_data_b, mw_fwd);
    assign dx_next.insn   = fd_insn;
    assign dx_load        = !stall; // low puts a bubble in D/X

endmodule

// File: source/dlx_core.sv
// ==============================
// five-stage DLX core, regfile inside
// imem and dmem live outside, no handshake
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module dlx_core (
    input  logic               clock,
    input  logic               rst_n,
    output logic [`DATA_W-1:0] address_imem,
    input  logic [`DATA_W-1:0] q_imem,
    output logic [`DATA_W-1:0] address_dmem,
    output logic [`DATA_W-1:0] data,
    output logic               wren,
    input  logic [`DATA_W-1:0] q_dmem
);

    logic [`REG_ADDR_W-1:0] rd_addr_a;
    logic [`REG_ADDR_W-1:0] rd_addr_b;
    logic [`DATA_W-1:0]     rd_data_a;
    logic [`DATA_W-1:0]     rd_data_b;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0]     wr_data;
    isa_pkg::insn_t         dx_insn;
    isa_pkg::insn_t         xm_insn;
    pipe_pkg::fwd_t         xm_fwd;
    pipe_pkg::fwd_t         mw_fwd;
    pipe_pkg::dx_t          dx_next;
    pipe_pkg::xm_t          xm;
    logic                   dx_load;

    reg_file u_reg_file (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    decode_stage u_decode (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (isa_pkg::insn_t'(q_imem)),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .dx_insn      (dx_insn),
        .xm_insn      (xm_insn),
        .xm_fwd       (xm_fwd),
        .mw_fwd       (mw_fwd),
        .dx_next      (dx_next),
        .dx_load      (dx_load)
    );

    execute_stage u_execute (
        .clock   (clock),
        .rst_n   (rst_n),
        .dx_next (dx_next),
        .dx_load (dx_load),
        .dx_insn (dx_insn),
        .mw_fwd  (mw_fwd),
        .xm_fwd  (xm_fwd),
        .xm_insn (xm_insn),
        .xm      (xm)
    );

    result_stage u_result (
        .clock        (clock),
        .rst_n        (rst_n),
        .xm           (xm),
        .mw_fwd       (mw_fwd),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

endmodule

// File: source/execute_stage.sv
// ==============================
// execute, D/X and X/M registers
// lw result is never bypassed from X/M, decode stalls instead
// ==============================
`timescale 1ns/10ps

module execute_stage (
    input  logic           clock,
    input  logic           rst_n,
    input  pipe_pkg::dx_t  dx_next,
    input  logic           dx_load,
    output isa_pkg::insn_t dx_insn,
    input  pipe_pkg::fwd_t mw_fwd,
    output pipe_pkg::fwd_t xm_fwd,
    output isa_pkg::insn_t xm_insn,
    output pipe_pkg::xm_t  xm
);

    pipe_pkg::dx_t     dx;
    isa_pkg::reg_idx_t src_b;
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b_reg;
    isa_pkg::word_t    op_b;
    isa_pkg::word_t    alu_out;
    isa_pkg::alu_op_e  alu_sel;
    logic              use_imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx <= '0; // insn field is NOP
        end else if (dx_load) begin
            dx <= dx_next;
        end else begin
            dx.insn <= isa_pkg::NOP; // stall bubble, values left stale
        end
    end

    assign dx_insn = dx.insn;

    // second source is rt for R-type, rd for sw and branches
    assign src_b = (dx.insn.opcode == isa_pkg::op_alu) ? dx.insn.rt : dx.insn.rd;

    // XM first, then MW
    assign op_a     = pipe_pkg::fwd_sel(dx.insn.rs,
                          pipe_pkg::fwd_sel(dx.insn.rs, dx.rs_val, mw_fwd), xm_fwd);
    assign op_b_reg = pipe_pkg::fwd_sel(src_b,
                          pipe_pkg::fwd_sel(src_b, dx.rt_val, mw_fwd), xm_fwd);

    assign use_imm = dx.insn.opcode == isa_pkg::op_addi || dx.insn.opcode == isa_pkg::op_lw
                     || dx.insn.opcode == isa_pkg::op_sw;
    assign op_b    = use_imm ? isa_pkg::imm_sext(dx.insn) : op_b_reg;
    assign alu_sel = (dx.insn.opcode == isa_pkg::op_alu) ? dx.insn.alu_op
                                                         : isa_pkg::alu_add; // rs + imm

    alu u_alu (
        .operand_a (op_a),
        .operand_b (op_b),
        .op        (alu_sel),
        .shamt     (dx.insn.shamt),
        .result    (alu_out),
        .not_equal (),
        .less_than ()
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm <= '0;
        end else begin
            xm.alu_val <= alu_out;
            xm.st_data <= op_b_reg; // rd value, meaningful for sw only
            xm.insn    <= dx.insn;
        end
    end

    assign xm_insn    = xm.insn;
    assign xm_fwd.wr  = isa_pkg::writes_rd(xm.insn);
    assign xm_fwd.rd  = xm.insn.rd;
    assign xm_fwd.val = xm.alu_val; // address for lw, never consumed

endmodule

// File: source/isa_pkg.sv
// ==============================
// DLX insn format, kept subset only
// imm and target are views over the low bits
// ==============================
`include "cpu_config.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]     word_t;    // one data word
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t; // register number

    typedef enum logic [4:0] {
        op_alu  = 5'b00000, // R-type, function in alu_op
        op_j    = 5'b00001,
        op_bne  = 5'b00010, // taken if rd != rs
        op_addi = 5'b00101,
        op_blt  = 5'b00110, // taken if rd < rs, signed
        op_sw   = 5'b00111,
        op_lw   = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100, // by shamt
        alu_sra = 5'b00101  // by shamt, sign fill
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode; // [31:27]
        logic [4:0] rd;     // [26:22]
        logic [4:0] rs;     // [21:17]
        logic [4:0] rt;     // [16:12]
        logic [4:0] shamt;  // [11:7]
        alu_op_e    alu_op; // [6:2]
        logic [1:0] pad;
    } insn_t;

    localparam insn_t NOP = '0; // add r0, r0, r0

    // low 17 bits, sign extended
    function automatic word_t imm_sext(insn_t insn);
        logic [31:0] raw;
        raw = insn;
        return {{(`DATA_W-17){raw[16]}}, raw[16:0]};
    endfunction

    // low 27 bits, absolute word address
    function automatic word_t jump_target(insn_t insn);
        logic [31:0] raw;
        raw = insn;
        return {{(`DATA_W-27){1'b0}}, raw[26:0]};
    endfunction

    // alu, addi and lw write rd, never r0
    function automatic logic writes_rd(insn_t insn);
        return (insn.opcode == op_alu || insn.opcode == op_addi || insn.opcode == op_lw)
            && insn.rd != '0;
    endfunction

endpackage

// File: source/pipe_pkg.sv
// ==============================
// stage register contents and bypass source
// needs isa_pkg compiled first
// ==============================
package pipe_pkg;

    typedef struct packed {
        isa_pkg::word_t rs_val; // rs from regfile
        isa_pkg::word_t rt_val; // rt for R-type, rd otherwise
        isa_pkg::insn_t insn;
    } dx_t;

    typedef struct packed {
        isa_pkg::word_t alu_val; // result or memory address
        isa_pkg::word_t st_data; // rd value for sw
        isa_pkg::insn_t insn;
    } xm_t;

    typedef struct packed {
        isa_pkg::word_t alu_val;
        isa_pkg::word_t ld_val;  // dmem word, used by lw
        isa_pkg::insn_t insn;
    } mw_t;

    // result offered by a later stage
    typedef struct packed {
        logic              wr;  // owner already excluded r0
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    val;
    } fwd_t;

    // bypass one source over a base value, nest for priority
    function automatic isa_pkg::word_t fwd_sel(isa_pkg::reg_idx_t src,
                                               isa_pkg::word_t base, fwd_t fwd);
        return (fwd.wr && fwd.rd == src) ? fwd.val : base;
    endfunction

endpackage

// File: source/reg_file.sv
// ==============================
// 2R1W register file, r0 reads zero
// write lands on the edge, same-cycle read is old
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module reg_file (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`REG_ADDR_W-1:0] rd_addr_b,
    output logic [`DATA_W-1:0]     rd_data_a,
    output logic [`DATA_W-1:0]     rd_data_b,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data
);

    logic [`DATA_W-1:0] regs [1:`NUM_REGS-1]; // no storage for r0

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0; // all regs start at zero
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a]; // r0 hardwired
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// File: source/result_stage.sv
// ==============================
// memory access and write-back
// dmem is combinational read, write on the edge with wren
// ==============================
`timescale 1ns/10ps
`include "cpu_config.svh"

module result_stage (
    input  logic                   clock,
    input  logic                   rst_n,
    input  pipe_pkg::xm_t          xm,
    output pipe_pkg::fwd_t         mw_fwd,
    output logic [`DATA_W-1:0]     address_dmem,
    output logic [`DATA_W-1:0]     data,
    output logic                   wren,
    input  logic [`DATA_W-1:0]     q_dmem,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`DATA_W-1:0]     wr_data
);

    pipe_pkg::mw_t  mw;
    isa_pkg::word_t wb_val;

    assign address_dmem = xm.alu_val;                                  // rs + imm
    assign data         = pipe_pkg::fwd_sel(xm.insn.rd, xm.st_data, mw_fwd); // lw then sw
    assign wren         = xm.insn.opcode == isa_pkg::op_sw;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw <= '0;
        end else begin
            mw.alu_val <= xm.alu_val;
            mw.ld_val  <= q_dmem;
            mw.insn    <= xm.insn;
        end
    end

    assign wb_val = (mw.insn.opcode == isa_pkg::op_lw) ? mw.ld_val : mw.alu_val;

    assign mw_fwd.wr  = isa_pkg::writes_rd(mw.insn);
    assign mw_fwd.rd  = mw.insn.rd;
    assign mw_fwd.val = wb_val;

    assign wr_en   = mw_fwd.wr;
    assign wr_addr = mw.insn.rd;
    assign wr_data = wb_val;

endmodule

// File: tb.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/dlx_core.sv
sim/tb_dlx_core.sv
